// File: logic/prio_pkg.sv
////////////////////////////////////////////////////////////////////////////
// request selector shared constants
// request width, tree split, APB address map and register fields
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package prio_pkg;

    // request side
    localparam int unsigned req_width = 12;
    // converter tree fan-in per level
    localparam int unsigned req_split = 2;

    // APB bus sizes
    localparam int unsigned apb_addr_width = 4;
    localparam int unsigned apb_data_width = 32;

    // register byte offsets
    localparam logic [apb_addr_width-1:0] addr_ctrl  = 4'h0;
    localparam logic [apb_addr_width-1:0] addr_mask  = 4'h4;
    localparam logic [apb_addr_width-1:0] addr_grant = 4'h8;
    localparam logic [apb_addr_width-1:0] addr_count = 4'hC;

    // CTRL fields
    localparam int unsigned ctrl_enable_bit = 0;

endpackage: prio_pkg

`default_nettype wire

// File: logic/sel_cfg_if.sv
////////////////////////////////////////////////////////////////////////////
// selector configuration and status link
// enable and mask go to the selector, grant status comes back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface sel_cfg_if;

    // control from the register block
    logic                           enable;
    logic [prio_pkg::req_width-1:0] mask;
    // registered grant from the selector
    logic [prio_pkg::req_width-1:0] grant;
    logic                           grant_vld;

    // register block side
    modport regs (output enable, output mask, input grant, input grant_vld);

    // selector side, mirror of regs
    modport sel (input enable, input mask, output grant, output grant_vld);

endinterface: sel_cfg_if

`default_nettype wire

// File: logic/pry2oht_tree.sv
////////////////////////////////////////////////////////////////////////////
// priority to one-hot tree
// WIDTH must be a power of SPLIT, each level splits into SPLIT groups
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pry2oht_tree #(
    parameter int unsigned WIDTH     = 16,
    parameter int unsigned SPLIT     = 2,
    // "LSB" picks the rightmost bit, "MSB" the leftmost
    parameter string       DIRECTION = "LSB"
)(
    input  logic [WIDTH-1:0] pry,
    output logic [WIDTH-1:0] oht,
    output logic             vld
);

    // group width one level down
    localparam int unsigned SUB = WIDTH/SPLIT;

    // candidates at this level and the one-hot winner among them
    logic [SPLIT-1:0] sel_in;
    logic [SPLIT-1:0] sel;

    // shared pick over SPLIT candidates
    // scan towards the preferred end so the last hit wins
    always_comb begin: pick
        int unsigned k;
        sel = '0;
        for (int i = 0; i < SPLIT; i++) begin
            k = (DIRECTION == "LSB") ? SPLIT-1-i : i;
            if (sel_in[k]) begin
                sel    = '0;
                sel[k] = 1'b1;
            end
        end
    end

    // any candidate at all
    assign vld = |sel_in;

    generate
    if (WIDTH == SPLIT) begin: leaf
        // leaf level, the candidates are the request bits
        assign sel_in = pry;
        assign oht    = sel;
    end: leaf
    else begin: node
        logic [SPLIT-1:0][SUB-1:0] grp_oht;

        for (genvar g = 0; g < SPLIT; g++) begin: grp
            pry2oht_tree #(
                .WIDTH     (SUB),
                .SPLIT     (SPLIT),
                .DIRECTION (DIRECTION)
            ) sub0 (
                .pry (pry[g*SUB +: SUB]),
                .oht (grp_oht[g]),
                .vld (sel_in[g])
            );

            // only the winning group passes its one-hot
            assign oht[g*SUB +: SUB] = grp_oht[g] & {SUB{sel[g]}};
        end: grp
    end: node
    endgenerate

endmodule: pry2oht_tree

`default_nettype wire

// File: logic/pry2oht.sv
////////////////////////////////////////////////////////////////////////////
// priority to one-hot converter with zero padding
// pads to the next power of SPLIT, runs the tree, crops the result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pry2oht #(
    parameter int unsigned WIDTH     = 32,
    parameter int unsigned SPLIT     = 2,
    // "LSB" picks the rightmost bit, "MSB" the leftmost
    parameter string       DIRECTION = "LSB"
)(
    input  logic [WIDTH-1:0] pry,
    output logic [WIDTH-1:0] oht,
    output logic             vld
);

    localparam int unsigned WIDTH_LOG = $clog2(WIDTH);
    localparam int unsigned SPLIT_LOG = $clog2(SPLIT);
    // keeps the level count defined while SPLIT is being rejected
    localparam int unsigned STEP_LOG  = (SPLIT_LOG == 0) ? 1 : SPLIT_LOG;
    // levels rounded up so the padded width covers WIDTH
    localparam int unsigned POWER_LOG = (WIDTH_LOG + STEP_LOG - 1)/STEP_LOG;
    localparam int unsigned POWER     = SPLIT**POWER_LOG;

    generate
    if ((SPLIT < 2) || (SPLIT != (2**SPLIT_LOG))) begin: bad_split
        $error("SPLIT must be a power of two, at least 2");
    end: bad_split
    else if (WIDTH != POWER) begin: padded
        logic [POWER-1:0] pry_pad;
        logic [POWER-1:0] oht_pad;

        // upper lines tied low, they never win
        assign pry_pad = POWER'(pry);

        pry2oht_tree #(
            .WIDTH     (POWER),
            .SPLIT     (SPLIT),
            .DIRECTION (DIRECTION)
        ) tree0 (
            .pry (pry_pad),
            .oht (oht_pad),
            .vld (vld)
        );

        // drop the padding lines
        assign oht = WIDTH'(oht_pad);
    end: padded
    else begin: direct
        pry2oht_tree #(
            .WIDTH     (WIDTH),
            .SPLIT     (SPLIT),
            .DIRECTION (DIRECTION)
        ) tree0 (
            .pry (pry),
            .oht (oht),
            .vld (vld)
        );
    end: direct
    endgenerate

endmodule: pry2oht

`default_nettype wire

// File: logic/req_select.sv
////////////////////////////////////////////////////////////////////////////
// request selector
// masks and enables the requests, registers the rightmost as a grant
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module req_select (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [prio_pkg::req_width-1:0] req,
    sel_cfg_if.sel                         cfg
);

    // masked and enabled requests, this cycle
    logic [prio_pkg::req_width-1:0] req_masked;
    // converter output
    logic [prio_pkg::req_width-1:0] oht;
    logic                           oht_vld;
    // grant stage
    logic [prio_pkg::req_width-1:0] grant_q;
    logic                           grant_vld_q;

    assign req_masked = req & cfg.mask & {prio_pkg::req_width{cfg.enable}};

    // rightmost active request
    pry2oht #(
        .WIDTH     (prio_pkg::req_width),
        .SPLIT     (prio_pkg::req_split),
        .DIRECTION ("LSB")
    ) conv0 (
        .pry (req_masked),
        .oht (oht),
        .vld (oht_vld)
    );

    // one cycle from sampled request to grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q     <= '0;
            grant_vld_q <= 1'b0;
        end else begin
            // oht is already zero when nothing is active
            grant_q     <= oht;
            grant_vld_q <= oht_vld;
        end
    end

    assign cfg.grant     = grant_q;
    assign cfg.grant_vld = grant_vld_q;

endmodule: req_select

`default_nettype wire

// File: logic/sel_regs.sv
////////////////////////////////////////////////////////////////////////////
// selector register block, APB slave
// CTRL and MASK configure, GRANT and COUNT report granted cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sel_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    // APB
    input  logic [prio_pkg::apb_addr_width-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [prio_pkg::apb_data_width-1:0] pwdata,
    output logic [prio_pkg::apb_data_width-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    // to the selector
    sel_cfg_if.regs                             cfg
);

    logic                                access;
    logic                                addr_ok;
    logic                                enable_q;
    logic [prio_pkg::req_width-1:0]      mask_q;
    logic [prio_pkg::req_width-1:0]      last_grant_q;
    logic [prio_pkg::apb_data_width-1:0] count_q;

    ////////////////////////////////////////////////////////////////////////////
    // access decode
    ////////////////////////////////////////////////////////////////////////////

    // access phase, never extended
    assign access = psel & penable;
    assign pready = 1'b1;

    assign addr_ok = (paddr == prio_pkg::addr_ctrl)  || (paddr == prio_pkg::addr_mask) ||
                     (paddr == prio_pkg::addr_grant) || (paddr == prio_pkg::addr_count);

    // error only on unmapped offsets, GRANT and COUNT writes are dropped quietly
    assign pslverr = access & ~addr_ok;

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q     <= 1'b0;
            mask_q       <= '1;
            last_grant_q <= '0;
            count_q      <= '0;
        end else begin
            // config writes land on the access edge
            if (access && pwrite && (paddr == prio_pkg::addr_ctrl)) begin
                enable_q <= pwdata[prio_pkg::ctrl_enable_bit];
            end
            if (access && pwrite && (paddr == prio_pkg::addr_mask)) begin
                mask_q <= pwdata[prio_pkg::req_width-1:0];
            end
            // status tracks every granted cycle, count wraps
            if (cfg.grant_vld) begin
                last_grant_q <= cfg.grant;
                count_q      <= count_q + 1'b1;
            end
        end
    end

    assign cfg.enable = enable_q;
    assign cfg.mask   = mask_q;

    // read mux, values held before the closing edge
    always_comb begin
        prdata = '0;
        case (paddr)
            prio_pkg::addr_ctrl:  prdata[prio_pkg::ctrl_enable_bit] = enable_q;
            prio_pkg::addr_mask:  prdata[prio_pkg::req_width-1:0]   = mask_q;
            prio_pkg::addr_grant: prdata[prio_pkg::req_width-1:0]   = last_grant_q;
            prio_pkg::addr_count: prdata                            = count_q;
            default:              prdata                            = '0;
        endcase
    end

endmodule: sel_regs

`default_nettype wire

// File: logic/prio_sel_top.sv
////////////////////////////////////////////////////////////////////////////
// priority request selector, top level
// APB register block feeding the request selector
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prio_sel_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // APB slave port
    input  logic [prio_pkg::apb_addr_width-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [prio_pkg::apb_data_width-1:0] pwdata,
    output logic [prio_pkg::apb_data_width-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    // requests and grant
    input  logic [prio_pkg::req_width-1:0]      req,
    output logic [prio_pkg::req_width-1:0]      gnt,
    output logic                                gnt_vld
);

    // config and status between registers and selector
    sel_cfg_if cfg_if ();

    sel_regs regs0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_if)
    );

    req_select sel0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .cfg   (cfg_if)
    );

    // grant seen by the outside is the same registered grant the status uses
    assign gnt     = cfg_if.grant;
    assign gnt_vld = cfg_if.grant_vld;

endmodule: prio_sel_top

`default_nettype wire

// File: sim/prio_sel_asserts.sv
////////////////////////////////////////////////////////////////////////////
// request selector assertions
// grant shape checks, bound into req_select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prio_sel_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic [prio_pkg::req_width-1:0] req_masked,
    input logic [prio_pkg::req_width-1:0] grant,
    input logic                           grant_vld
);

    // never more than one line granted
    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("grant has more than one bit set");

    // no grant lines without valid, and valid means a line
    grant_idle: assert property (@(posedge clk) disable iff (!rst_n)
        grant_vld ? (grant != '0) : (grant == '0))
        else $error("grant and grant valid disagree");

    // the granted line was requested and unmasked one cycle earlier
    grant_subset: assert property (@(posedge clk) disable iff (!rst_n)
        grant_vld |-> ((grant & ~$past(req_masked)) == '0))
        else $error("grant not among the previous masked requests");

endmodule: prio_sel_asserts

bind req_select prio_sel_asserts asserts0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_masked (req_masked),
    .grant      (grant_q),
    .grant_vld  (grant_vld_q)
);

`default_nettype wire

// File: sim/prio_sel_tb.sv
////////////////////////////////////////////////////////////////////////////
// request selector testbench
// random APB and request stimulus checked against a cycle model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prio_sel_tb;

    logic                                clk;
    logic                                rst_n;
    logic [prio_pkg::apb_addr_width-1:0] paddr;
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [prio_pkg::apb_data_width-1:0] pwdata;
    logic [prio_pkg::apb_data_width-1:0] prdata;
    logic                                pready;
    logic                                pslverr;
    logic [prio_pkg::req_width-1:0]      req;
    logic [prio_pkg::req_width-1:0]      gnt;
    logic                                gnt_vld;

    // model of the configuration, the outputs and the status registers
    logic                                m_en;
    logic [prio_pkg::req_width-1:0]      m_mask;
    logic [prio_pkg::req_width-1:0]      cur_gnt;
    logic                                cur_vld;
    logic [prio_pkg::req_width-1:0]      m_last;
    logic [prio_pkg::apb_data_width-1:0] m_count;
    // requests limited to lines 8 to 11
    logic                                upper_only;

    integer      seed        = 32'h309f_9d05;
    int unsigned cycle_count = 0;
    int          error_count = 0;
    // reset 10, idle 28, full mask 308, mask mix 328, address map 56, disable 24
    int unsigned cycle_limit = 4 * 754;

    prio_sel_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req),
        .gnt     (gnt),
        .gnt_vld (gnt_vld)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, the test sequence did not finish within %0d cycles", cycle_limit);
            stop_with_fail();
        end
    end

    task automatic stop_with_fail();
        error_count++;
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_grant(input logic [prio_pkg::req_width-1:0] exp_gnt,
                               input logic exp_vld);
        if (gnt !== exp_gnt) begin
            $display("Error: gnt expected %h actual %h", exp_gnt, gnt);
            stop_with_fail();
        end else if (gnt_vld !== exp_vld) begin
            $display("Error: gnt_vld expected %h actual %h", exp_vld, gnt_vld);
            stop_with_fail();
        end
    endtask

    task automatic check_rdata(input logic [prio_pkg::apb_data_width-1:0] exp_data);
        if (prdata !== exp_data) begin
            $display("Error: prdata at %h expected %h actual %h", paddr, exp_data, prdata);
            stop_with_fail();
        end
    endtask

    task automatic check_err(input logic exp_err);
        if (pslverr !== exp_err) begin
            $display("Error: pslverr at %h expected %h actual %h", paddr, exp_err, pslverr);
            stop_with_fail();
        end
    endtask

    task automatic check_ready(input logic exp_rdy);
        if (pready !== exp_rdy) begin
            $display("Error: pready at %h expected %h actual %h", paddr, exp_rdy, pready);
            stop_with_fail();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // model rules
    ////////////////////////////////////////////////////////////////////////////

    // two's complement trick isolates the lowest set bit
    function automatic logic [prio_pkg::req_width-1:0] lowest_set(
        input logic [prio_pkg::req_width-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    function automatic logic is_mapped(input logic [prio_pkg::apb_addr_width-1:0] addr);
        return (addr == prio_pkg::addr_ctrl) || (addr == prio_pkg::addr_mask) ||
               (addr == prio_pkg::addr_grant) || (addr == prio_pkg::addr_count);
    endfunction

    function automatic logic [prio_pkg::apb_data_width-1:0] reg_value(
        input logic [prio_pkg::apb_addr_width-1:0] addr);
        logic [prio_pkg::apb_data_width-1:0] v;
        v = '0;
        if (addr == prio_pkg::addr_ctrl) v[prio_pkg::ctrl_enable_bit] = m_en;
        else if (addr == prio_pkg::addr_mask) v[prio_pkg::req_width-1:0] = m_mask;
        else if (addr == prio_pkg::addr_grant) v[prio_pkg::req_width-1:0] = m_last;
        else if (addr == prio_pkg::addr_count) v = m_count;
        return v;
    endfunction

    // one clock: predict, let the edge pass, check, drive new requests
    task automatic tick();
        logic [prio_pkg::req_width-1:0] nxt;
        nxt = lowest_set(req & m_mask & {prio_pkg::req_width{m_en}});
        @(posedge clk);
        // status registers take the grant that was on the outputs
        if (cur_vld) begin
            m_last  = cur_gnt;
            m_count = m_count + 1;
        end
        cur_gnt = nxt;
        cur_vld = |nxt;
        #1;
        check_grant(cur_gnt, cur_vld);
        req = prio_pkg::req_width'($random(seed));
        if (upper_only) req[7:0] = '0;
    endtask

    // setup and access phase, reads checked against the model mid access
    task automatic apb_access(input logic [prio_pkg::apb_addr_width-1:0] addr,
                              input logic write,
                              input logic [prio_pkg::apb_data_width-1:0] wdata);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        #2 check_err(1'b0);
        tick();
        penable = 1'b1;
        #2 check_err(!is_mapped(addr));
        // no wait states, every access ends in its access phase
        check_ready(1'b1);
        if (!write && is_mapped(addr)) check_rdata(reg_value(addr));
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        // the write landed on the closing edge
        if (write && (addr == prio_pkg::addr_ctrl)) m_en = wdata[prio_pkg::ctrl_enable_bit];
        if (write && (addr == prio_pkg::addr_mask)) m_mask = wdata[prio_pkg::req_width-1:0];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin: main
        rst_n      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        req        = '0;
        upper_only = 1'b0;
        m_en       = 1'b0;
        m_mask     = '1;
        cur_gnt    = '0;
        cur_vld    = 1'b0;
        m_last     = '0;
        m_count    = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // disabled after reset, no grants and reset values
        repeat (20) tick();
        apb_access(prio_pkg::addr_ctrl, 1'b0, '0);
        apb_access(prio_pkg::addr_mask, 1'b0, '0);
        apb_access(prio_pkg::addr_grant, 1'b0, '0);
        apb_access(prio_pkg::addr_count, 1'b0, '0);

        // enabled with the full mask
        apb_access(prio_pkg::addr_ctrl, 1'b1, 32'h1 << prio_pkg::ctrl_enable_bit);
        apb_access(prio_pkg::addr_ctrl, 1'b0, '0);
        repeat (300) tick();
        apb_access(prio_pkg::addr_grant, 1'b0, '0);
        apb_access(prio_pkg::addr_count, 1'b0, '0);

        // mask writes mixed into the request stream
        for (int i = 0; i < 40; i++) begin
            apb_access(prio_pkg::addr_mask, 1'b1, $random(seed));
            repeat (5) tick();
        end
        // readback of the last random mask
        apb_access(prio_pkg::addr_mask, 1'b0, '0);
        // upper lines alone must still win
        apb_access(prio_pkg::addr_mask, 1'b1, '1);
        upper_only = 1'b1;
        repeat (40) tick();
        upper_only = 1'b0;
        apb_access(prio_pkg::addr_grant, 1'b0, '0);
        apb_access(prio_pkg::addr_count, 1'b0, '0);

        // unmapped offsets error, status writes are dropped
        for (int a = 0; a < 16; a++) begin
            if (!is_mapped(a)) begin
                apb_access(a, 1'b0, '0);
                apb_access(a, 1'b1, $random(seed));
            end
        end
        apb_access(prio_pkg::addr_grant, 1'b1, $random(seed));
        apb_access(prio_pkg::addr_count, 1'b1, $random(seed));
        apb_access(prio_pkg::addr_grant, 1'b0, '0);
        apb_access(prio_pkg::addr_count, 1'b0, '0);

        // disable, count freezes
        apb_access(prio_pkg::addr_ctrl, 1'b1, '0);
        repeat (20) tick();
        apb_access(prio_pkg::addr_count, 1'b0, '0);

        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_fail();
        end
    end

endmodule: prio_sel_tb

`default_nettype wire

// File: verilog.f
logic/prio_pkg.sv
logic/sel_cfg_if.sv
logic/pry2oht_tree.sv
logic/pry2oht.sv
logic/req_select.sv
logic/sel_regs.sv
logic/prio_sel_top.sv
sim/prio_sel_asserts.sv
sim/prio_sel_tb.sv

// File: Bender.yml
package:
  name: prio_sel

sources:
  - logic/prio_pkg.sv
  - logic/sel_cfg_if.sv
  - logic/pry2oht_tree.sv
  - logic/pry2oht.sv
  - logic/req_select.sv
  - logic/sel_regs.sv
  - logic/prio_sel_top.sv
  - target: test
    files:
      - sim/prio_sel_asserts.sv
      - sim/prio_sel_tb.sv
